// File: Makefile
TOP = tb_exec

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module $(TOP) -o V$(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "ALL CHECKS PASSED"

lint:
	verilator --lint-only --timing --assert -Wall -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

// File: count_bit.sv
module count_bit (
	input  logic            bit_val,
	input  exec_pkg::word_t val,
	output exec_pkg::word_t count
);

logic run;

// stops at the first bit that differs
always_comb begin
	count = '0;
	run = 1'b1;
	for (int i = $bits(val) - 1; i >= 0; i--) begin
		if (run && val[i] == bit_val) begin
			count = count + 32'd1;
		end else begin
			run = 1'b0;
		end
	end
end

endmodule

// File: exec_pkg.sv
package exec_pkg;

typedef logic [31:0] word_t;
// hi in the upper half
typedef logic [63:0] dword_t;

localparam int MULDIV_STEPS = 32;
typedef logic [5:0] step_t;

typedef enum logic [5:0] {
	OP_NOP, OP_INVALID,
	OP_AND, OP_OR, OP_XOR, OP_NOR, OP_LUI,
	OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
	OP_SLL, OP_SLLV, OP_SRL, OP_SRLV, OP_SRA, OP_SRAV,
	OP_SLT, OP_SLTU, OP_CLZ, OP_CLO,
	OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO, OP_MOVZ, OP_MOVN,
	OP_MULT, OP_MULTU, OP_DIV, OP_DIVU,
	OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU, OP_MUL,
	OP_BEQ, OP_BNE, OP_BLTZ, OP_BGEZ, OP_BLEZ, OP_BGTZ,
	OP_BLTZAL, OP_BGEZAL, OP_JAL, OP_JALR,
	OP_TEQ, OP_TNE, OP_TGE, OP_TLT, OP_TGEU, OP_TLTU,
	OP_SYSCALL, OP_BREAK
} oper_t;

typedef enum logic [1:0] {
	CF_NONE, CF_BRANCH, CF_JUMP_IMM, CF_JUMP_REG
} cf_t;

typedef logic [4:0] exc_code_t;
localparam exc_code_t EXC_SYS = 5'd8;
localparam exc_code_t EXC_BP  = 5'd9;
localparam exc_code_t EXC_RI  = 5'd10;
localparam exc_code_t EXC_OV  = 5'd12;
localparam exc_code_t EXC_TR  = 5'd13;

typedef enum logic [3:0] {
	MD_MULT, MD_MULTU, MD_DIV, MD_DIVU,
	MD_MADD, MD_MADDU, MD_MSUB, MD_MSUBU, MD_MUL
} md_kind_t;

endpackage

// File: exec_top.sv
module exec_top (
	input  logic                clk,
	input  logic                rst,
	input  logic                flush,
	input  logic                valid,
	input  exec_pkg::oper_t     op,
	input  exec_pkg::word_t     reg1,
	input  exec_pkg::word_t     reg2,
	input  exec_pkg::word_t     instr,
	input  exec_pkg::word_t     pc,
	output exec_pkg::word_t     result,
	output logic                kill_rd,
	output logic                ex_valid,
	output exec_pkg::exc_code_t exc_code,
	output logic                br_valid,
	output logic                br_taken,
	output exec_pkg::cf_t       br_cf,
	output exec_pkg::word_t     br_target,
	output logic                stall_req
);

import exec_pkg::*;

logic md_start, md_load, md_step, md_done;
logic cnt_clear, cnt_enable, cnt_last;
logic hilo_we, hi_only, lo_only;
md_kind_t md_kind;
dword_t md_result, hilo, hilo_wdata;

instr_exec i_exec (
	.valid, .op, .reg1, .reg2, .instr, .pc,
	.hilo, .md_result, .md_done,
	.result, .kill_rd, .ex_valid, .exc_code,
	.br_valid, .br_taken, .br_cf, .br_target,
	.md_start, .md_kind,
	.hilo_we, .hi_only, .lo_only, .hilo_wdata
);

muldiv_ctrl i_ctrl (
	.clk, .rst, .flush,
	.start(md_start), .last(cnt_last),
	.load(md_load), .step(md_step),
	.cnt_clear, .cnt_enable,
	.busy(stall_req), .done(md_done)
);

iter_counter i_cnt (
	.clk, .rst,
	.clear(cnt_clear), .enable(cnt_enable),
	.count(), .last(cnt_last)
);

muldiv_datapath i_dp (
	.clk, .rst,
	.load(md_load), .step(md_step), .kind(md_kind),
	.reg1, .reg2, .hilo, .md_result
);

hilo_reg i_hilo (
	.clk, .rst,
	.we(hilo_we), .hi_only, .lo_only,
	.wdata(hilo_wdata), .hilo
);

endmodule

// File: filelist.f
exec_pkg.sv
count_bit.sv
iter_counter.sv
muldiv_ctrl.sv
muldiv_datapath.sv
hilo_reg.sv
instr_exec.sv
exec_top.sv
tb_exec.sv

// File: hilo_reg.sv
module hilo_reg (
	input  logic             clk,
	input  logic             rst,
	input  logic             we,
	input  logic             hi_only,
	input  logic             lo_only,
	input  exec_pkg::dword_t wdata,
	output exec_pkg::dword_t hilo
);

always_ff @(posedge clk) begin
	if (rst) begin
		hilo <= '0;
	end else if (we) begin
		if (!lo_only)
			hilo[63:32] <= wdata[63:32];
		if (!hi_only)
			hilo[31:0] <= wdata[31:0];
	end
end

// mthi and mtlo are separate ops
assert property (@(posedge clk) disable iff (rst) !(hi_only && lo_only))
	else $error("hilo_reg: hi_only and lo_only together");

endmodule

// File: instr_exec.sv
module instr_exec (
	input  logic                valid,
	input  exec_pkg::oper_t     op,
	input  exec_pkg::word_t     reg1,
	input  exec_pkg::word_t     reg2,
	input  exec_pkg::word_t     instr,
	input  exec_pkg::word_t     pc,
	input  exec_pkg::dword_t    hilo,
	input  exec_pkg::dword_t    md_result,
	input  logic                md_done,
	output exec_pkg::word_t     result,
	output logic                kill_rd,
	output logic                ex_valid,
	output exec_pkg::exc_code_t exc_code,
	output logic                br_valid,
	output logic                br_taken,
	output exec_pkg::cf_t       br_cf,
	output exec_pkg::word_t     br_target,
	output logic                md_start,
	output exec_pkg::md_kind_t  md_kind,
	output logic                hilo_we,
	output logic                hi_only,
	output logic                lo_only,
	output exec_pkg::dword_t    hilo_wdata
);

import exec_pkg::*;

word_t add_u, sub_u, imm_ext, pc_plus4, clz_cnt, clo_cnt;
logic ov_add, ov_sub, signed_lt, unsigned_lt, reg_equal;
logic is_md, md_writes_hilo, trap_hit, ex_hit, is_cf;

assign add_u = reg1 + reg2;
assign sub_u = reg1 - reg2;
assign ov_add = (reg1[31] == reg2[31]) && (reg1[31] != add_u[31]);
assign ov_sub = (reg1[31] != reg2[31]) && (reg1[31] != sub_u[31]);
assign signed_lt = (reg1[31] != reg2[31]) ? reg1[31] : sub_u[31];
assign unsigned_lt = (reg1 < reg2);
assign reg_equal = (reg1 == reg2);

count_bit i_clz (.bit_val(1'b0), .val(reg1), .count(clz_cnt));
count_bit i_clo (.bit_val(1'b1), .val(reg1), .count(clo_cnt));

always_comb begin
	is_md = 1'b1;
	md_writes_hilo = 1'b1;
	md_kind = MD_MULT;
	case (op)
		OP_MULT:  md_kind = MD_MULT;
		OP_MULTU: md_kind = MD_MULTU;
		OP_DIV:   md_kind = MD_DIV;
		OP_DIVU:  md_kind = MD_DIVU;
		OP_MADD:  md_kind = MD_MADD;
		OP_MADDU: md_kind = MD_MADDU;
		OP_MSUB:  md_kind = MD_MSUB;
		OP_MSUBU: md_kind = MD_MSUBU;
		// mul goes to rd only and leaves hi/lo untouched
		OP_MUL: begin
			md_kind = MD_MUL;
			md_writes_hilo = 1'b0;
		end
		default: begin
			is_md = 1'b0;
			md_writes_hilo = 1'b0;
		end
	endcase
end

assign md_start = valid && is_md;

assign hi_only = valid && (op == OP_MTHI);
assign lo_only = valid && (op == OP_MTLO);
assign hilo_we = hi_only || lo_only || (md_done && md_writes_hilo);
assign hilo_wdata = (hi_only || lo_only) ? {reg1, reg1} : md_result;

assign kill_rd = valid && ((op == OP_MOVZ && reg2 != '0) || (op == OP_MOVN && reg2 == '0));

always_comb begin
	case (op)
		OP_LUI:  result = {instr[15:0], 16'b0};
		OP_AND:  result = reg1 & reg2;
		OP_OR:   result = reg1 | reg2;
		OP_XOR:  result = reg1 ^ reg2;
		OP_NOR:  result = ~(reg1 | reg2);
		OP_ADD, OP_ADDU: result = add_u;
		OP_SUB, OP_SUBU: result = sub_u;
		OP_SLL:  result = reg2 << instr[10:6];
		OP_SLLV: result = reg2 << reg1[4:0];
		OP_SRL:  result = reg2 >> instr[10:6];
		OP_SRLV: result = reg2 >> reg1[4:0];
		OP_SRA:  result = $signed(reg2) >>> instr[10:6];
		OP_SRAV: result = $signed(reg2) >>> reg1[4:0];
		OP_SLT:  result = {31'b0, signed_lt};
		OP_SLTU: result = {31'b0, unsigned_lt};
		OP_CLZ:  result = clz_cnt;
		OP_CLO:  result = clo_cnt;
		OP_MOVZ, OP_MOVN: result = reg1;
		OP_MFHI: result = hilo[63:32];
		OP_MFLO: result = hilo[31:0];
		OP_MUL:  result = md_result[31:0];
		OP_JAL, OP_JALR, OP_BLTZAL, OP_BGEZAL: result = pc + 32'd8;
		default: result = '0;
	endcase
end

// priority ri, trap, break, syscall, overflow
always_comb begin
	case (op)
		OP_TEQ:  trap_hit = reg_equal;
		OP_TNE:  trap_hit = !reg_equal;
		OP_TGE:  trap_hit = !signed_lt;
		OP_TLT:  trap_hit = signed_lt;
		OP_TGEU: trap_hit = !unsigned_lt;
		OP_TLTU: trap_hit = unsigned_lt;
		default: trap_hit = 1'b0;
	endcase
	ex_hit = 1'b1;
	if (op == OP_INVALID)
		exc_code = EXC_RI;
	else if (trap_hit)
		exc_code = EXC_TR;
	else if (op == OP_BREAK)
		exc_code = EXC_BP;
	else if (op == OP_SYSCALL)
		exc_code = EXC_SYS;
	else if ((op == OP_ADD && ov_add) || (op == OP_SUB && ov_sub))
		exc_code = EXC_OV;
	else begin
		ex_hit = 1'b0;
		exc_code = '0;
	end
end

assign ex_valid = valid && ex_hit;

assign imm_ext = {{16{instr[15]}}, instr[15:0]};
assign pc_plus4 = pc + 32'd4;

always_comb begin
	is_cf = 1'b1;
	br_taken = 1'b1;
	br_cf = CF_NONE;
	br_target = pc_plus4 + {imm_ext[29:0], 2'b00};
	case (op)
		OP_BEQ: br_taken = reg_equal;
		OP_BNE: br_taken = !reg_equal;
		OP_BLTZ, OP_BLTZAL: br_taken = reg1[31];
		OP_BGEZ, OP_BGEZAL: br_taken = !reg1[31];
		OP_BLEZ: br_taken = reg1[31] || (reg1 == '0);
		OP_BGTZ: br_taken = !reg1[31] && (reg1 != '0);
		OP_JAL: begin
			br_cf = CF_JUMP_IMM;
			br_target = {pc_plus4[31:28], instr[25:0], 2'b00};
		end
		OP_JALR: begin
			br_cf = CF_JUMP_REG;
			br_target = reg1;
		end
		default: begin
			is_cf = 1'b0;
			br_taken = 1'b0;
			br_target = '0;
		end
	endcase
	// a branch not taken keeps kind none
	if (is_cf && br_cf == CF_NONE && br_taken)
		br_cf = CF_BRANCH;
end

assign br_valid = valid && is_cf;

// the op must still be held when the sequencer finishes
always_comb begin
	assert final (!md_done || md_start)
		else $error("instr_exec: md_done without a held multi-cycle op");
end

endmodule

// File: iter_counter.sv
module iter_counter (
	input  logic            clk,
	input  logic            rst,
	input  logic            clear,
	input  logic            enable,
	output exec_pkg::step_t count,
	output logic            last
);

import exec_pkg::*;

always_ff @(posedge clk) begin
	if (rst || clear) begin
		count <= '0;
	end else if (enable) begin
		count <= count + step_t'(1);
	end
end

assign last = (count == step_t'(MULDIV_STEPS - 1));

// clear only at issue and enable only while running
assert property (@(posedge clk) disable iff (rst) !(clear && enable))
	else $error("iter_counter: clear and enable together");

endmodule

// File: muldiv_ctrl.sv
module muldiv_ctrl (
	input  logic clk,
	input  logic rst,
	input  logic flush,
	input  logic start,
	input  logic last,
	output logic load,
	output logic step,
	output logic cnt_clear,
	output logic cnt_enable,
	output logic busy,
	output logic done
);

typedef enum logic [1:0] {
	S_IDLE,
	S_RUN,
	S_DONE
} state_t;

state_t state, state_next;

always_ff @(posedge clk) begin
	if (rst || flush) begin
		state <= S_IDLE;
	end else begin
		state <= state_next;
	end
end

always_comb begin
	state_next = state;
	unique case (state)
		S_IDLE: begin
			if (start)
				state_next = S_RUN;
		end
		S_RUN: begin
			if (last)
				state_next = S_DONE;
		end
		S_DONE: state_next = S_IDLE;
		default: state_next = S_IDLE;
	endcase
end

// issue cycle
assign load      = (state == S_IDLE) && start;
assign cnt_clear = load;

// one datapath step per run cycle
assign step       = (state == S_RUN);
assign cnt_enable = step;

assign busy = load || step;
// a flushed op must not reach hi/lo
assign done = (state == S_DONE) && !flush;

assert property (@(posedge clk) disable iff (rst) done |-> $past(state == S_RUN && last))
	else $error("muldiv_ctrl: done without a final run step");

endmodule

// File: muldiv_datapath.sv
module muldiv_datapath (
	input  logic               clk,
	input  logic               rst,
	input  logic               load,
	input  logic               step,
	input  exec_pkg::md_kind_t kind,
	input  exec_pkg::word_t    reg1,
	input  exec_pkg::word_t    reg2,
	input  exec_pkg::dword_t   hilo,
	output exec_pkg::dword_t   md_result
);

import exec_pkg::*;

logic is_signed, is_div;
logic is_div_r, neg_hi, neg_lo, acc_add, acc_sub;
word_t a_mag, b_mag, divisor;
dword_t work, acc, fixed;
logic [32:0] mul_sum, div_trial, div_diff;

always_comb begin
	is_signed = 1'b0;
	is_div = 1'b0;
	case (kind)
		MD_MULT, MD_MADD, MD_MSUB, MD_MUL: is_signed = 1'b1;
		MD_DIV: begin
			is_signed = 1'b1;
			is_div = 1'b1;
		end
		MD_DIVU: is_div = 1'b1;
		default: ;
	endcase
end

assign a_mag = (is_signed && reg1[31]) ? -reg1 : reg1;
assign b_mag = (is_signed && reg2[31]) ? -reg2 : reg2;

always_ff @(posedge clk) begin
	if (rst) begin
		is_div_r <= 1'b0;
		neg_hi <= 1'b0;
		neg_lo <= 1'b0;
		acc_add <= 1'b0;
		acc_sub <= 1'b0;
	end else if (load) begin
		is_div_r <= is_div;
		// remainder follows the dividend
		neg_hi <= is_signed && is_div && reg1[31];
		neg_lo <= is_signed && (reg1[31] ^ reg2[31]);
		acc_add <= (kind == MD_MADD) || (kind == MD_MADDU);
		acc_sub <= (kind == MD_MSUB) || (kind == MD_MSUBU);
	end
end

// shift-add keeps the partial product in the upper half
assign mul_sum = {1'b0, work[63:32]} + (work[0] ? {1'b0, divisor} : 33'b0);

// restoring divide builds the remainder above the quotient bits
assign div_trial = work[63:31];
assign div_diff  = div_trial - {1'b0, divisor};

always_ff @(posedge clk) begin
	if (load) begin
		work <= {32'b0, a_mag};
		divisor <= b_mag;
		acc <= hilo;
	end else if (step) begin
		if (!is_div_r)
			work <= {mul_sum, work[31:1]};
		else if (div_diff[32])
			work <= {div_trial[31:0], work[30:0], 1'b0};
		else
			work <= {div_diff[31:0], work[30:0], 1'b1};
	end
end

always_comb begin
	if (is_div_r) begin
		fixed[63:32] = neg_hi ? -work[63:32] : work[63:32];
		fixed[31:0] = neg_lo ? -work[31:0] : work[31:0];
	end else begin
		fixed = neg_lo ? -work : work;
	end
	if (acc_add)
		md_result = acc + fixed;
	else if (acc_sub)
		md_result = acc - fixed;
	else
		md_result = fixed;
end

endmodule

// File: tb_exec.sv
module tb_exec;

import exec_pkg::*;

localparam int STALL_LIMIT = 100;

logic clk, rst, flush, valid;
oper_t op;
word_t reg1, reg2, instr, pc;
word_t result, br_target;
logic kill_rd, ex_valid, br_valid, br_taken, stall_req;
exc_code_t exc_code;
cf_t br_cf;

word_t rng = 32'd88;
int errors = 0;
int errors_mark = 0;
int tests = 0;

// reference state and expected outputs
dword_t model_hilo, md_expect;
logic done_flag;
word_t exp_result, exp_target;
logic exp_kill, exp_exv, exp_brv, exp_taken, check_res, single_op;
exc_code_t exp_exc;
cf_t exp_cf;

oper_t alu_ops [19] = '{OP_AND, OP_OR, OP_XOR, OP_NOR, OP_LUI, OP_ADD, OP_ADDU, OP_SUB,
	OP_SUBU, OP_SLL, OP_SLLV, OP_SRL, OP_SRLV, OP_SRA, OP_SRAV, OP_SLT, OP_SLTU, OP_CLZ, OP_CLO};
oper_t trap_ops [6] = '{OP_TEQ, OP_TNE, OP_TGE, OP_TLT, OP_TGEU, OP_TLTU};
oper_t br_ops [10] = '{OP_BEQ, OP_BNE, OP_BLTZ, OP_BGEZ, OP_BLEZ, OP_BGTZ, OP_BLTZAL,
	OP_BGEZAL, OP_JAL, OP_JALR};
oper_t md_ops [9] = '{OP_MULT, OP_MULTU, OP_DIV, OP_DIVU, OP_MADD, OP_MADDU, OP_MSUB,
	OP_MSUBU, OP_MUL};

exec_top i_dut (
	.clk, .rst, .flush, .valid, .op, .reg1, .reg2, .instr, .pc,
	.result, .kill_rd, .ex_valid, .exc_code,
	.br_valid, .br_taken, .br_cf, .br_target, .stall_req
);

always #4 clk = ~clk;

function automatic word_t next_rand();
	rng = rng ^ (rng << 13);
	rng = rng ^ (rng >> 17);
	rng = rng ^ (rng << 5);
	return rng;
endfunction

function automatic logic is_md_op(oper_t o);
	return o inside {OP_MULT, OP_MULTU, OP_DIV, OP_DIVU, OP_MADD, OP_MADDU, OP_MSUB,
		OP_MSUBU, OP_MUL};
endfunction

function automatic logic is_cf_op(oper_t o);
	return o inside {OP_BEQ, OP_BNE, OP_BLTZ, OP_BGEZ, OP_BLEZ, OP_BGTZ, OP_BLTZAL,
		OP_BGEZAL, OP_JAL, OP_JALR};
endfunction

function automatic word_t lead_count(word_t v, logic b);
	word_t n;
	int i;
	n = '0;
	i = 31;
	while (i >= 0 && v[i] == b) begin
		n++;
		i--;
	end
	return n;
endfunction

// hi/lo after a multi-cycle op with the remainder in hi for divides
function automatic dword_t md_model(oper_t o, word_t a, word_t b, dword_t hl);
	logic sgn;
	word_t am, bm, q, r;
	dword_t prod;
	sgn = o inside {OP_MULT, OP_MADD, OP_MSUB, OP_MUL, OP_DIV};
	if (o == OP_DIV || o == OP_DIVU) begin
		am = (sgn && a[31]) ? 32'd0 - a : a;
		bm = (sgn && b[31]) ? 32'd0 - b : b;
		if (bm == '0) begin
			q = '1;
			r = am;
		end else begin
			q = am / bm;
			r = am % bm;
		end
		if (sgn && (a[31] != b[31]))
			q = 32'd0 - q;
		if (sgn && a[31])
			r = 32'd0 - r;
		return {r, q};
	end
	if (sgn)
		prod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
	else
		prod = {32'd0, a} * {32'd0, b};
	case (o)
		OP_MADD, OP_MADDU: return hl + prod;
		OP_MSUB, OP_MSUBU: return hl - prod;
		default: return prod;
	endcase
endfunction

function automatic word_t ref_result(oper_t o, word_t a, word_t b, word_t ins, word_t p,
		dword_t hl, dword_t md);
	case (o)
		OP_AND: return a & b;
		OP_OR: return a | b;
		OP_XOR: return a ^ b;
		OP_NOR: return ~(a | b);
		OP_LUI: return {ins[15:0], 16'h0};
		OP_ADD, OP_ADDU: return a + b;
		OP_SUB, OP_SUBU: return a - b;
		OP_SLL: return b << ins[10:6];
		OP_SLLV: return b << a[4:0];
		OP_SRL: return b >> ins[10:6];
		OP_SRLV: return b >> a[4:0];
		OP_SRA: return word_t'($signed(b) >>> ins[10:6]);
		OP_SRAV: return word_t'($signed(b) >>> a[4:0]);
		OP_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
		OP_CLZ: return lead_count(a, 1'b0);
		OP_CLO: return lead_count(a, 1'b1);
		OP_MOVZ, OP_MOVN: return a;
		OP_MFHI: return hl[63:32];
		OP_MFLO: return hl[31:0];
		OP_MUL: return md[31:0];
		OP_JAL, OP_JALR, OP_BLTZAL, OP_BGEZAL: return p + 32'd8;
		default: return '0;
	endcase
endfunction

// first match wins from ri down to overflow
function automatic exc_code_t ref_exc(oper_t o, word_t a, word_t b);
	longint sa, sb, s;
	logic trap;
	sa = $signed(a);
	sb = $signed(b);
	case (o)
		OP_TEQ: trap = (a == b);
		OP_TNE: trap = (a != b);
		OP_TGE: trap = (sa >= sb);
		OP_TLT: trap = (sa < sb);
		OP_TGEU: trap = (a >= b);
		OP_TLTU: trap = (a < b);
		default: trap = 1'b0;
	endcase
	s = (o == OP_SUB) ? sa - sb : sa + sb;
	if (o == OP_INVALID)
		return EXC_RI;
	if (trap)
		return EXC_TR;
	if (o == OP_BREAK)
		return EXC_BP;
	if (o == OP_SYSCALL)
		return EXC_SYS;
	if ((o == OP_ADD || o == OP_SUB) && (s > 64'sd2147483647 || s < -64'sd2147483648))
		return EXC_OV;
	return '0;
endfunction

function automatic logic ref_taken(oper_t o, word_t a, word_t b);
	case (o)
		OP_BEQ: return a == b;
		OP_BNE: return a != b;
		OP_BLTZ, OP_BLTZAL: return $signed(a) < 0;
		OP_BGEZ, OP_BGEZAL: return $signed(a) >= 0;
		OP_BLEZ: return $signed(a) <= 0;
		OP_BGTZ: return $signed(a) > 0;
		OP_JAL, OP_JALR: return 1'b1;
		default: return 1'b0;
	endcase
endfunction

always_comb begin
	md_expect = md_model(op, reg1, reg2, model_hilo);
	exp_result = ref_result(op, reg1, reg2, instr, pc, model_hilo, md_expect);
	exp_exc = ref_exc(op, reg1, reg2);
	exp_exv = valid && (exp_exc != '0);
	exp_brv = valid && is_cf_op(op);
	exp_taken = ref_taken(op, reg1, reg2);
	if (op == OP_JAL) begin
		exp_cf = CF_JUMP_IMM;
		exp_target = {pc[31:28] + ((pc[27:0] > 28'hffffffb) ? 4'd1 : 4'd0), instr[25:0], 2'b00};
	end else if (op == OP_JALR) begin
		exp_cf = CF_JUMP_REG;
		exp_target = reg1;
	end else begin
		exp_cf = exp_taken ? CF_BRANCH : CF_NONE;
		exp_target = pc + 32'd4 + {{14{instr[15]}}, instr[15:0], 2'b00};
	end
	// movz writes on a zero reg2 and movn on a nonzero one
	if (op == OP_MOVZ || op == OP_MOVN)
		exp_kill = valid && ((reg2 == '0) != (op == OP_MOVZ));
	else
		exp_kill = 1'b0;
	// multi-cycle results only count in the done cycle
	check_res = valid && (!is_md_op(op) || (op == OP_MUL && done_flag));
	single_op = valid && !is_md_op(op);
end

always @(posedge clk) begin
	if (rst)
		model_hilo <= '0;
	else if (valid && op == OP_MTHI)
		model_hilo[63:32] <= reg1;
	else if (valid && op == OP_MTLO)
		model_hilo[31:0] <= reg1;
	else if (done_flag && op != OP_MUL)
		model_hilo <= md_expect;
end

task automatic bad_value(string name, word_t expected, word_t actual);
	$display("Error %0t: %s expected %h, got %h", $time, name, expected, actual);
	errors++;
endtask

a_result: assert property (@(posedge clk) disable iff (rst) check_res |-> result == exp_result)
	else bad_value("result", $sampled(exp_result), $sampled(result));
a_kill: assert property (@(posedge clk) disable iff (rst) kill_rd == exp_kill)
	else bad_value("kill_rd", word_t'($sampled(exp_kill)), word_t'($sampled(kill_rd)));
a_exv: assert property (@(posedge clk) disable iff (rst) ex_valid == exp_exv)
	else bad_value("ex_valid", word_t'($sampled(exp_exv)), word_t'($sampled(ex_valid)));
a_exc: assert property (@(posedge clk) disable iff (rst) exp_exv |-> exc_code == exp_exc)
	else bad_value("exc_code", word_t'($sampled(exp_exc)), word_t'($sampled(exc_code)));
a_brv: assert property (@(posedge clk) disable iff (rst) br_valid == exp_brv)
	else bad_value("br_valid", word_t'($sampled(exp_brv)), word_t'($sampled(br_valid)));
a_taken: assert property (@(posedge clk) disable iff (rst) exp_brv |-> br_taken == exp_taken)
	else bad_value("br_taken", word_t'($sampled(exp_taken)), word_t'($sampled(br_taken)));
a_cf: assert property (@(posedge clk) disable iff (rst) exp_brv |-> br_cf == exp_cf)
	else bad_value("br_cf", word_t'($sampled(exp_cf)), word_t'($sampled(br_cf)));
a_target: assert property (@(posedge clk) disable iff (rst) exp_brv |-> br_target == exp_target)
	else bad_value("br_target", $sampled(exp_target), $sampled(br_target));
a_stall: assert property (@(posedge clk) disable iff (rst) single_op |-> !stall_req)
	else bad_value("stall_req", 32'd0, 32'd1);

task automatic issue(oper_t o, word_t a, word_t b, word_t ins, word_t p);
	@(posedge clk);
	valid <= 1'b1;
	op <= o;
	reg1 <= a;
	reg2 <= b;
	instr <= ins;
	pc <= p;
endtask

task automatic read_hilo();
	issue(OP_MFHI, 32'h0, 32'h0, 32'h0, 32'h0);
	issue(OP_MFLO, 32'h0, 32'h0, 32'h0, 32'h0);
endtask

// op stays held through the done cycle
task automatic run_md(oper_t o, word_t a, word_t b);
	int n;
	n = 0;
	issue(o, a, b, 32'h0, 32'h0);
	@(negedge clk);
	while (stall_req && n < STALL_LIMIT) begin
		n++;
		@(negedge clk);
	end
	if (stall_req) begin
		$display("timeout: stall_req still high after %0d cycles", n);
		$display("CHECKS FAILED");
		$finish;
	end else begin
		assert (n == 33) else begin
			$display("Error %0t: stall_req cycles expected 33, got %0d", $time, n);
			errors++;
		end
		done_flag <= 1'b1;
		@(posedge clk);
		done_flag <= 1'b0;
		valid <= 1'b0;
		op <= OP_NOP;
	end
endtask

task automatic end_test(string name);
	@(posedge clk);
	valid <= 1'b0;
	op <= OP_NOP;
	@(negedge clk);
	tests++;
	$display("test %0d %s: %0d errors", tests, name, errors - errors_mark);
	errors_mark = errors;
endtask

initial begin
	word_t a, b;
	int idx;
	clk = 1'b0;
	rst = 1'b1;
	flush = 1'b0;
	valid = 1'b0;
	op = OP_NOP;
	reg1 = '0;
	reg2 = '0;
	instr = '0;
	pc = '0;
	done_flag = 1'b0;
	repeat (3) @(posedge clk);
	rst <= 1'b0;

	for (int k = 0; k < 200; k++) begin
		a = next_rand();
		b = next_rand();
		case (k % 8)
			0: a = '0;
			1: a = '1;
			2: b = '0;
			3: b = '1;
			default: ;
		endcase
		idx = int'(next_rand() % 32'd19);
		issue(alu_ops[idx], a, b, next_rand(), next_rand());
	end
	issue(OP_CLZ, 32'h0, 32'h0, 32'h0, 32'h0);
	issue(OP_CLZ, 32'hffff_ffff, 32'h0, 32'h0, 32'h0);
	issue(OP_CLO, 32'hffff_ffff, 32'h0, 32'h0, 32'h0);
	issue(OP_CLO, 32'h0, 32'h0, 32'h0, 32'h0);
	end_test("alu");

	issue(OP_ADD, 32'h7fff_ffff, 32'h1, 32'h0, 32'h0);
	issue(OP_ADD, 32'h8000_0000, 32'hffff_ffff, 32'h0, 32'h0);
	issue(OP_ADD, 32'h5, 32'h6, 32'h0, 32'h0);
	issue(OP_ADDU, 32'h7fff_ffff, 32'h1, 32'h0, 32'h0);
	issue(OP_SUB, 32'h8000_0000, 32'h1, 32'h0, 32'h0);
	issue(OP_SUB, 32'h7fff_ffff, 32'hffff_ffff, 32'h0, 32'h0);
	issue(OP_SUB, 32'h9, 32'h3, 32'h0, 32'h0);
	for (int k = 0; k < 24; k++) begin
		case (k % 4)
			0: issue(trap_ops[k / 4], 32'h5, 32'h5, 32'h0, 32'h0);
			1: issue(trap_ops[k / 4], 32'h3, 32'h9, 32'h0, 32'h0);
			2: issue(trap_ops[k / 4], 32'h9, 32'h3, 32'h0, 32'h0);
			default: issue(trap_ops[k / 4], 32'hffff_ffff, 32'h1, 32'h0, 32'h0);
		endcase
	end
	issue(OP_SYSCALL, 32'h0, 32'h0, 32'h0, 32'h0);
	issue(OP_BREAK, 32'h0, 32'h0, 32'h0, 32'h0);
	issue(OP_INVALID, 32'h7fff_ffff, 32'h1, 32'h0, 32'h0);
	end_test("exceptions");

	for (int k = 0; k < 80; k++) begin
		b = next_rand();
		case (next_rand() % 32'd4)
			0: a = '0;
			1: a = b;
			2: a = next_rand() | 32'h8000_0000;
			default: a = next_rand() & 32'h7fff_ffff;
		endcase
		issue(br_ops[k % 10], a, b, next_rand(), next_rand() & ~32'h3);
	end
	end_test("branches");

	// hi/lo still zero from reset
	read_hilo();
	issue(OP_MOVZ, 32'hdead_0001, 32'h0, 32'h0, 32'h0);
	issue(OP_MOVZ, 32'hdead_0002, 32'h5, 32'h0, 32'h0);
	issue(OP_MOVN, 32'hdead_0003, 32'h0, 32'h0, 32'h0);
	issue(OP_MOVN, 32'hdead_0004, 32'h5, 32'h0, 32'h0);
	issue(OP_MTHI, next_rand(), 32'h0, 32'h0, 32'h0);
	issue(OP_MTLO, next_rand(), 32'h0, 32'h0, 32'h0);
	read_hilo();
	issue(OP_MTLO, next_rand(), 32'h0, 32'h0, 32'h0);
	read_hilo();
	end_test("moves and hilo");

	issue(OP_MTHI, next_rand(), 32'h0, 32'h0, 32'h0);
	issue(OP_MTLO, next_rand(), 32'h0, 32'h0, 32'h0);
	for (int k = 0; k < 27; k++) begin
		a = next_rand();
		b = next_rand() >> (next_rand() % 32'd24);
		run_md(md_ops[k % 9], a, b);
		if (md_ops[k % 9] != OP_MUL)
			read_hilo();
	end
	run_md(OP_DIV, next_rand() & 32'h7fff_ffff, 32'h0);
	read_hilo();
	run_md(OP_DIV, next_rand() | 32'h8000_0000, 32'h0);
	read_hilo();
	run_md(OP_DIVU, next_rand(), 32'h0);
	read_hilo();
	end_test("multiply and divide");

	issue(OP_MTHI, 32'h1234_5678, 32'h0, 32'h0, 32'h0);
	issue(OP_MTLO, 32'h9abc_def0, 32'h0, 32'h0, 32'h0);
	issue(OP_MULTU, 32'hffff_ffff, 32'hffff_ffff, 32'h0, 32'h0);
	repeat (6) @(posedge clk);
	flush <= 1'b1;
	@(negedge clk);
	assert (stall_req) else begin
		$display("Error %0t: stall_req expected 1, got 0", $time);
		errors++;
	end
	@(posedge clk);
	flush <= 1'b0;
	valid <= 1'b0;
	op <= OP_NOP;
	@(negedge clk);
	assert (!stall_req) else begin
		$display("Error %0t: stall_req expected 0, got 1", $time);
		errors++;
	end
	read_hilo();
	end_test("flush");

	$display("%0d tests, %0d errors", tests, errors);
	if (errors == 0) begin
		$display("ALL CHECKS PASSED");
	end else begin
		$display("CHECKS FAILED");
	end
	$finish;
end

endmodule
